// ==== verilog/armPkg.sv ====
// Shared types, control bundles and encoding constants for the
// single-cycle ARMv4 subset core with a Wishbone data port
package armPkg;

   typedef logic [31:0] word_t;       // Data, address and instruction word
   typedef logic [3:0]  regAddr_t;    // Register number r0..r15
   typedef logic [3:0]  cond_t;       // Instr[31:28]

   // Status flags in CPSR order
   typedef struct packed
   {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   typedef enum logic [1:0]
   {
      aluAdd,
      aluSub,
      aluAnd,
      aluOrr
   } aluOp_t;

   // Immediate extension kinds
   typedef enum logic [1:0]
   {
      immDp8,         // Zero-extended imm8
      immMem12,       // Zero-extended imm12
      immBranch24     // Sign-extended imm24, word offset
   } immSrc_t;

   // Datapath steering, independent of the condition
   typedef struct packed
   {
      immSrc_t immSrc;
      logic    aluSrc;     // Second operand is the immediate
      logic    memToReg;   // Result from the bus, LDR
      logic    storeSrc;   // Second read address from Rd, STR
      aluOp_t  aluOp;
   } pathCtrl_t;

   // Controls before the condition check
   typedef struct packed
   {
      logic       regWrite;
      logic       memWrite;
      logic       memAccess;
      logic       branch;
      logic [1:0] flagWrite;   // [1] NZ, [0] CV
   } condCtrl_t;

   // Controls after the condition check
   typedef struct packed
   {
      logic regWrite;
      logic memWrite;
      logic memAccess;
      logic branch;
   } execCtrl_t;

   // Wishbone classic master outputs
   typedef struct packed
   {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [3:0] sel;
      word_t      adr;
      word_t      datOut;
   } wbReq_t;

   localparam word_t    PcStep      = 32'd4;
   localparam word_t    PcReadAhead = 32'd8;   // R15 reads as PC+8
   localparam regAddr_t RegPc       = 4'd15;

   // Instr[27:26]
   localparam logic [1:0] OpDp     = 2'b00;
   localparam logic [1:0] OpMem    = 2'b01;
   localparam logic [1:0] OpBranch = 2'b10;

   // Instr[24:21] of data-processing
   localparam logic [3:0] FnAnd = 4'b0000;
   localparam logic [3:0] FnSub = 4'b0010;
   localparam logic [3:0] FnAdd = 4'b0100;
   localparam logic [3:0] FnOrr = 4'b1100;

endpackage

// ==== verilog/armDecoder.sv ====
// Instruction decoder
// Main decoder classifies DP, LDR/STR and B; ALU decoder picks the
// operation and the flag-write halves. Anything else decodes as a no-op
module armDecoder
(
   input  armPkg::word_t      instr,
   output armPkg::pathCtrl_t  pathCtrl,
   output armPkg::condCtrl_t  condCtrl
);
   import armPkg::*;

   logic [1:0] op;
   logic [3:0] fn;
   logic       immBit;        // Immediate operand
   logic       sBit;          // Update flags
   logic       loadBit;       // L bit, same position as S
   logic       linkBit;       // BL, not supported
   aluOp_t     dpAluOp;
   logic [1:0] dpFlagWrite;
   logic       dpKnown;       // One of ADD/SUB/AND/ORR

   assign op      = instr[27:26];
   assign fn      = instr[24:21];
   assign immBit  = instr[25];
   assign sBit    = instr[20];
   assign loadBit = instr[20];
   assign linkBit = instr[24];

   // ALU decoder
   always_comb
   begin
      dpKnown     = 1'b1;
      dpAluOp     = aluAdd;
      dpFlagWrite = {sBit, 1'b0};   // Logic ops leave C and V alone
      case (fn)
         FnAdd: dpFlagWrite = {sBit, sBit};
         FnSub:
         begin
            dpAluOp     = aluSub;
            dpFlagWrite = {sBit, sBit};
         end
         FnAnd: dpAluOp = aluAnd;
         FnOrr: dpAluOp = aluOrr;
         default:
         begin
            dpKnown     = 1'b0;      // Other DP functions are no-ops
            dpFlagWrite = 2'b00;
         end
      endcase
   end

   // Main decoder
   always_comb
   begin
      pathCtrl.immSrc   = immDp8;
      pathCtrl.aluSrc   = 1'b0;
      pathCtrl.memToReg = 1'b0;
      pathCtrl.storeSrc = 1'b0;
      pathCtrl.aluOp    = aluAdd;     // Also the LDR/STR address add
      condCtrl          = '0;         // No side effects by default
      case (op)
         OpDp:
         begin
            if (dpKnown)
            begin
               pathCtrl.aluSrc    = immBit;
               pathCtrl.aluOp     = dpAluOp;
               condCtrl.regWrite  = 1'b1;
               condCtrl.flagWrite = dpFlagWrite;
            end
         end
         OpMem:
         begin
            pathCtrl.immSrc    = immMem12;
            pathCtrl.aluSrc    = 1'b1;   // Base plus offset
            condCtrl.memAccess = 1'b1;
            if (loadBit)
            begin
               pathCtrl.memToReg = 1'b1;
               condCtrl.regWrite = 1'b1;
            end
            else
            begin
               pathCtrl.storeSrc = 1'b1;   // Store data from Rd
               condCtrl.memWrite = 1'b1;
            end
         end
         OpBranch:
         begin
            if (!linkBit)
            begin
               pathCtrl.immSrc = immBranch24;
               condCtrl.branch = 1'b1;
            end
         end
         default: ;   // Op 11 unimplemented
      endcase
   end

endmodule

// ==== verilog/condUnit.sv ====
// Condition unit
// Keeps the NZ and CV flag halves, checks the condition field against
// them and qualifies register, memory and branch controls
module condUnit
(
   input  logic               clk,
   input  logic               reset,
   input  armPkg::cond_t      cond,
   input  armPkg::condCtrl_t  condCtrl,
   input  armPkg::flags_t     aluFlags,
   input  logic               done,        // Instruction completes this cycle
   output armPkg::execCtrl_t  execCtrl
);
   import armPkg::*;

   flags_t flags;      // Stored NZCV
   logic   condEx;     // Condition passed
   logic   ge;         // Signed greater or equal
   logic   nzEn;
   logic   cvEn;

   assign nzEn = condCtrl.flagWrite[1] & condEx & done;
   assign cvEn = condCtrl.flagWrite[0] & condEx & done;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (nzEn)
         begin
            flags.n <= aluFlags.n;
            flags.z <= aluFlags.z;
         end
         if (cvEn)
         begin
            flags.c <= aluFlags.c;
            flags.v <= aluFlags.v;
         end
      end
   end

   assign ge = (flags.n == flags.v);

   always_comb
   begin
      case (cond)
         4'b0000: condEx = flags.z;                  // EQ
         4'b0001: condEx = ~flags.z;                 // NE
         4'b0010: condEx = flags.c;                  // CS
         4'b0011: condEx = ~flags.c;                 // CC
         4'b0100: condEx = flags.n;                  // MI
         4'b0101: condEx = ~flags.n;                 // PL
         4'b0110: condEx = flags.v;                  // VS
         4'b0111: condEx = ~flags.v;                 // VC
         4'b1000: condEx = flags.c & ~flags.z;       // HI
         4'b1001: condEx = ~flags.c | flags.z;       // LS
         4'b1010: condEx = ge;                       // GE
         4'b1011: condEx = ~ge;                      // LT
         4'b1100: condEx = ~flags.z & ge;            // GT
         4'b1101: condEx = flags.z | ~ge;            // LE
         4'b1110: condEx = 1'b1;                     // AL
         default: condEx = 1'b0;                     // 1111 never executes
      endcase
   end

   // Failed condition turns the instruction into a no-op
   assign execCtrl.regWrite  = condCtrl.regWrite  & condEx;
   assign execCtrl.memWrite  = condCtrl.memWrite  & condEx;
   assign execCtrl.memAccess = condCtrl.memAccess & condEx;
   assign execCtrl.branch    = condCtrl.branch    & condEx;

endmodule

// ==== verilog/regFile.sv ====
// Register file, r0..r14 in flops
// Two combinational read ports, one write port at the clock edge.
// R15 reads as PC+8 and cannot be written
module regFile
(
   input  logic              clk,
   input  logic              we,
   input  armPkg::regAddr_t  ra1,
   input  armPkg::regAddr_t  ra2,
   input  armPkg::regAddr_t  wa,
   input  armPkg::word_t     wd,
   input  armPkg::word_t     pcAhead,     // PC+8
   output armPkg::word_t     rd1,
   output armPkg::word_t     rd2
);
   import armPkg::*;

   word_t regs [0:RegPc-1];   // Fifteen general registers

   always_ff @(posedge clk)
   begin
      if (we && (wa != RegPc))   // PC writes dropped
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == RegPc) ? pcAhead : regs[ra1];
   assign rd2 = (ra2 == RegPc) ? pcAhead : regs[ra2];

endmodule

// ==== verilog/armAlu.sv ====
// ALU for ADD, SUB, AND and ORR
// One 33-bit adder serves add and subtract, the carry out feeds C.
// C and V are only meaningful for the arithmetic ops
module armAlu
(
   input  armPkg::word_t   a,
   input  armPkg::word_t   b,
   input  armPkg::aluOp_t  aluOp,
   output armPkg::word_t   result,
   output armPkg::flags_t  aluFlags
);
   import armPkg::*;

   logic        isSub;
   logic        isArith;
   word_t       bInv;        // b or its complement
   logic [32:0] sum;

   assign isSub   = (aluOp == aluSub);
   assign isArith = (aluOp == aluAdd) || isSub;
   assign bInv    = isSub ? ~b : b;

   // a - b as a + ~b + 1
   assign sum = {1'b0, a} + {1'b0, bInv} + {32'd0, isSub};

   always_comb
   begin
      case (aluOp)
         aluAdd,
         aluSub:  result = sum[31:0];
         aluAnd:  result = a & b;
         default: result = a | b;      // ORR
      endcase
   end

   assign aluFlags.n = result[31];
   assign aluFlags.z = (result == '0);
   assign aluFlags.c = isArith & sum[32];    // No borrow on SUB

   // Operand signs agree after inversion but the sum sign differs
   assign aluFlags.v = isArith & ~(a[31] ^ b[31] ^ isSub) & (a[31] ^ sum[31]);

endmodule

// ==== verilog/armDatapath.sv ====
// Datapath of the single-cycle core
// PC and its adders, immediate extension, register file, ALU and the
// Wishbone classic data master. A data access stalls PC, flags and
// register write until the slave acknowledges
module armDatapath
(
   input  logic               clk,
   input  logic               reset,
   input  armPkg::word_t      instr,
   input  armPkg::pathCtrl_t  pathCtrl,
   input  armPkg::execCtrl_t  execCtrl,
   input  armPkg::word_t      wbDatIn,
   input  logic               wbAck,
   output armPkg::word_t      pc,
   output armPkg::flags_t     aluFlags,
   output armPkg::wbReq_t     wbReq,
   output logic               done        // Instruction retires at next edge
);
   import armPkg::*;

   word_t    pcPlus4;
   word_t    pcPlus8;
   word_t    pcNext;
   word_t    branchTarget;
   word_t    extImm;
   word_t    srcA;
   word_t    rd2;          // Register operand or store data
   word_t    srcB;
   word_t    aluResult;
   word_t    result;       // Write-back value
   regAddr_t ra2;
   logic     accessReq;    // Bus cycle requested
   logic     regWe;

   // Next PC
   assign pcPlus4      = pc + PcStep;
   assign pcPlus8      = pc + PcReadAhead;
   assign branchTarget = pcPlus8 + extImm;     // Offset already scaled
   assign pcNext       = execCtrl.branch ? branchTarget : pcPlus4;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (done)   // Hold through a bus stall
         pc <= pcNext;
   end

   // Immediate extension
   always_comb
   begin
      case (pathCtrl.immSrc)
         immDp8:      extImm = {24'd0, instr[7:0]};
         immMem12:    extImm = {20'd0, instr[11:0]};
         immBranch24: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
         default:     extImm = '0;
      endcase
   end

   // Register file
   assign ra2   = pathCtrl.storeSrc ? instr[15:12] : instr[3:0];   // Rd for STR, else Rm
   assign regWe = execCtrl.regWrite & done;                       // LDR writes at ack

   regFile i_regFile
   (
      .clk     (clk),
      .we      (regWe),
      .ra1     (instr[19:16]),     // Rn
      .ra2     (ra2),
      .wa      (instr[15:12]),     // Rd
      .wd      (result),
      .pcAhead (pcPlus8),
      .rd1     (srcA),
      .rd2     (rd2)
   );

   // ALU
   assign srcB = pathCtrl.aluSrc ? extImm : rd2;

   armAlu i_armAlu
   (
      .a        (srcA),
      .b        (srcB),
      .aluOp    (pathCtrl.aluOp),
      .result   (aluResult),
      .aluFlags (aluFlags)
   );

   assign result = pathCtrl.memToReg ? wbDatIn : aluResult;

   // Wishbone master, request held until ack
   assign accessReq = execCtrl.memAccess & ~reset;    // No bus cycle while in reset
   assign done      = ~accessReq | wbAck;

   assign wbReq.cyc    = accessReq;
   assign wbReq.stb    = accessReq;
   assign wbReq.we     = execCtrl.memWrite;
   assign wbReq.sel    = 4'b1111;                     // Word accesses only
   assign wbReq.adr    = {aluResult[31:2], 2'b00};
   assign wbReq.datOut = rd2;

endmodule

// ==== verilog/armCore.sv ====
// Top level of the single-cycle ARMv4 subset core
// Combinational instruction fetch port and a Wishbone classic data
// master; decoder, condition unit and datapath wired together
module armCore
(
   input  logic            clk,
   input  logic            reset,
   output armPkg::word_t   pc,
   input  armPkg::word_t   instr,      // Valid for the current pc
   output armPkg::wbReq_t  wbReq,
   input  armPkg::word_t   wbDatIn,
   input  logic            wbAck
);
   import armPkg::*;

   pathCtrl_t pathCtrl;
   condCtrl_t condCtrl;
   execCtrl_t execCtrl;
   flags_t    aluFlags;
   logic      done;

   armDecoder i_armDecoder
   (
      .instr    (instr),
      .pathCtrl (pathCtrl),
      .condCtrl (condCtrl)
   );

   condUnit i_condUnit
   (
      .clk      (clk),
      .reset    (reset),
      .cond     (instr[31:28]),
      .condCtrl (condCtrl),
      .aluFlags (aluFlags),
      .done     (done),
      .execCtrl (execCtrl)
   );

   armDatapath i_armDatapath
   (
      .clk      (clk),
      .reset    (reset),
      .instr    (instr),
      .pathCtrl (pathCtrl),
      .execCtrl (execCtrl),
      .wbDatIn  (wbDatIn),
      .wbAck    (wbAck),
      .pc       (pc),
      .aluFlags (aluFlags),
      .wbReq    (wbReq),
      .done     (done)
   );

endmodule

// ==== verification/armBusAssert.sv ====
// Wishbone master protocol and stall checks
// Bound into every armCore instance
module armBusAssert
(
   input logic            clk,
   input logic            reset,
   input armPkg::word_t   pc,
   input armPkg::wbReq_t  wbReq,
   input logic            wbAck
);

   // Strobe only inside a cycle
   stbInCyc: assert property (@(posedge clk) disable iff (reset) wbReq.stb |-> wbReq.cyc)
      else $error("stb high without cyc");

   // Request frozen until the slave acknowledges
   reqStable: assert property (@(posedge clk) disable iff (reset)
                               (wbReq.stb && !wbAck) |=> ($stable(wbReq.adr)
                                  && $stable(wbReq.we) && $stable(wbReq.datOut)))
      else $error("request changed before ack");

   pcHold: assert property (@(posedge clk) disable iff (reset)
                            (wbReq.cyc && !wbAck) |=> $stable(pc))   // Core stalled
      else $error("pc moved during a bus stall");

   noCycInReset: assert property (@(posedge clk) reset |-> !wbReq.cyc)
      else $error("cyc high during reset");

endmodule

bind armCore armBusAssert i_armBusAssert
(
   .clk   (clk),
   .reset (reset),
   .pc    (pc),
   .wbReq (wbReq),
   .wbAck (wbAck)
);

// ==== verification/armCoreTb.sv ====
// Testbench for the single-cycle ARMv4 subset core
// Random program against an instruction-set model, Wishbone slave
// memory with random wait states, PC and bus checks every cycle
module armCoreTb;
   import armPkg::*;

   localparam int ProgWords     = 256;
   localparam int DataWords     = 64;
   localparam int BodyEnd       = 240;            // Store tail starts here
   localparam int SelfIdx       = BodyEnd + 14;   // Branch to itself
   localparam int TimeoutCycles = ProgWords * 5 + 50;

   logic   clk;
   logic   reset;
   word_t  pc;
   word_t  instr;
   wbReq_t wbReq;
   word_t  wbDatIn;
   logic   wbAck;

   word_t  prog    [0:ProgWords-1];
   word_t  dataMem [0:DataWords-1];   // Slave memory
   integer seed;
   int     cycleCount;
   logic   pending;                   // Slave inside an access
   int     waitLeft;

   // Model state and its bus expectation
   word_t  mRegs [0:14];
   word_t  mMem  [0:DataWords-1];
   word_t  mPc;
   flags_t mFlags;
   logic   expAccess;
   logic   expWe;
   word_t  expAdr;
   word_t  expDat;

   armCore i_armCore
   (
      .clk     (clk),
      .reset   (reset),
      .pc      (pc),
      .instr   (instr),
      .wbReq   (wbReq),
      .wbDatIn (wbDatIn),
      .wbAck   (wbAck)
   );

   assign instr = prog[pc[9:2]];   // Combinational fetch

   initial clk = 1'b0;
   always #5 clk = ~clk;

   task automatic stopWithFailure(input string reason);
      $display("%s", reason);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkWord(input string name, input word_t expected, input word_t actual);
      assert (actual === expected)
      else
         stopWithFailure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
   endtask

   function automatic int pickBelow(input int n);
      int r;
      r = $random(seed);
      return int'(r & 32'h7fff_ffff) % n;
   endfunction

   function automatic word_t encDp(input cond_t c, input logic [3:0] fn, input logic imm,
                                   input logic s, input regAddr_t rn, input regAddr_t rd,
                                   input logic [7:0] low8);
      return {c, 2'b00, imm, fn, s, rn, rd, 4'd0, low8};   // No rotate, no shift
   endfunction

   // LDR/STR with base r0, P=1 U=1
   function automatic word_t encMem(input cond_t c, input logic load, input regAddr_t rd,
                                    input logic [11:0] off);
      return {c, 2'b01, 1'b0, 1'b1, 1'b1, 2'b00, load, 4'd0, rd, off};
   endfunction

   function automatic word_t randomDp(input cond_t c);
      logic [3:0] fn;
      logic       imm;
      logic       s;
      regAddr_t   rn;
      regAddr_t   rd;
      logic [7:0] low8;
      case (pickBelow(4))
         0:       fn = 4'b0000;   // AND
         1:       fn = 4'b0010;   // SUB
         2:       fn = 4'b0100;   // ADD
         default: fn = 4'b1100;   // ORR
      endcase
      imm  = (pickBelow(2) == 1);
      s    = (pickBelow(2) == 1);
      rn   = regAddr_t'(pickBelow(16));        // r15 reads PC+8
      rd   = regAddr_t'(1 + pickBelow(15));    // r0 stays zero
      low8 = imm ? 8'(pickBelow(256)) : {4'd0, 4'(pickBelow(16))};
      return encDp(c, fn, imm, s, rn, rd, low8);
   endfunction

   task automatic buildProgram();
      int    i;
      int    kind;
      int    maxOff;
      cond_t c;
      prog[0] = encDp(4'hE, 4'b0000, 1'b1, 1'b0, 4'd0, 4'd0, 8'd0);   // AND r0, r0, #0
      for (i = 1; i <= 14; i++)
         prog[i] = encDp(4'hE, 4'b1100, 1'b1, 1'b0, 4'd0, regAddr_t'(i), 8'(pickBelow(256)));
      for (i = 15; i < BodyEnd; i++)
      begin
         c      = (pickBelow(3) == 0) ? cond_t'(pickBelow(16)) : 4'hE;   // Mostly AL
         kind   = pickBelow(16);
         maxOff = BodyEnd - i - 2;   // Target no further than the tail
         if (kind < 10)
            prog[i] = randomDp(c);
         else if (kind < 13)
            prog[i] = encMem(c, kind == 10, regAddr_t'(1 + pickBelow(15)),
                             12'(pickBelow(DataWords) * 4));
         else if (kind < 15 && maxOff >= 0)
            prog[i] = {c, 3'b101, 1'b0, 24'(pickBelow((maxOff < 4 ? maxOff : 4) + 1))};
         else if (kind < 15)
            prog[i] = randomDp(c);
         else if (pickBelow(2) == 0)
            prog[i] = {c, 2'b11, 26'(pickBelow(1 << 26))};            // Op 11
         else
            prog[i] = encDp(c, 4'b1101, 1'b1, 1'b1, 4'd1, 4'd1, 8'hFF);   // MOV, unlisted
      end
      for (i = 1; i <= 14; i++)
         prog[BodyEnd + i - 1] = encMem(4'hE, 1'b0, regAddr_t'(i), 12'(i * 4));
      prog[SelfIdx]     = {4'hE, 3'b101, 1'b0, 24'hFF_FFFE};   // Offset -2 words
      prog[SelfIdx + 1] = 32'hEC00_0000;
   endtask

   function automatic word_t readReg(input regAddr_t r);
      return (r == 4'd15) ? mPc + 32'd8 : mRegs[r];
   endfunction

   // Even codes test a flag term, odd codes its inverse
   function automatic logic condPass(input cond_t c);
      logic ge;
      logic base;
      ge = (mFlags.n == mFlags.v);
      case (c[3:1])
         3'd0:    base = mFlags.z;
         3'd1:    base = mFlags.c;
         3'd2:    base = mFlags.n;
         3'd3:    base = mFlags.v;
         3'd4:    base = mFlags.c && !mFlags.z;   // HI
         3'd5:    base = ge;
         3'd6:    base = !mFlags.z && ge;         // GT
         default: base = 1'b1;                    // AL, and 1111 inverted
      endcase
      return c[0] ? !base : base;
   endfunction

   // Bus expectation for the current instruction, state update if it retires
   task automatic runModel(input logic complete);
      word_t       ins;
      logic        pass;
      logic        known;
      word_t       a;
      word_t       b;
      word_t       res;
      word_t       nextPc;
      logic [32:0] wide;
      regAddr_t    rd;
      flags_t      f;
      ins       = prog[mPc[9:2]];
      pass      = condPass(ins[31:28]);
      rd        = ins[15:12];
      a         = readReg(ins[19:16]);
      b         = ins[25] ? {24'd0, ins[7:0]} : readReg(ins[3:0]);
      nextPc    = mPc + 32'd4;
      expAccess = 1'b0;
      expWe     = 1'b0;
      expAdr    = a + {20'd0, ins[11:0]};
      expDat    = readReg(rd);
      case (ins[27:26])
         2'b00:
         begin
            known = 1'b1;
            res   = '0;
            f     = mFlags;                 // Logic ops keep C and V
            case (ins[24:21])
               4'b0100:
               begin
                  wide = {1'b0, a} + {1'b0, b};
                  res  = wide[31:0];
                  f.c  = wide[32];
                  f.v  = (a[31] == b[31]) && (res[31] != a[31]);
               end
               4'b0010:
               begin
                  res = a - b;
                  f.c = (a >= b);           // No borrow
                  f.v = (a[31] != b[31]) && (res[31] != a[31]);
               end
               4'b0000: res = a & b;
               4'b1100: res = a | b;
               default: known = 1'b0;
            endcase
            f.n = res[31];
            f.z = (res == '0);
            if (complete && pass && known)
            begin
               if (rd != 4'd15)
                  mRegs[rd] = res;
               if (ins[20])
                  mFlags = f;
            end
         end
         2'b01:
         begin
            expAccess = pass;
            expWe     = !ins[20];
            if (complete && pass && ins[20] && rd != 4'd15)
               mRegs[rd] = mMem[expAdr[7:2]];
            else if (complete && pass && !ins[20])
               mMem[expAdr[7:2]] = expDat;
         end
         2'b10:
         begin
            if (pass && !ins[24])
               nextPc = mPc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
         end
         default: ;
      endcase
      if (complete)
         mPc = nextPc;
   endtask

   // Sampled mid-cycle, after the slave has driven ack
   task automatic checkCycle();
      logic complete;
      complete = !wbReq.cyc || wbAck;   // Stalled while cyc waits for ack
      checkWord("pc", mPc, pc);
      runModel(complete);
      checkWord("bus cycle", word_t'(expAccess), word_t'(wbReq.cyc));
      checkWord("bus strobe", word_t'(expAccess), word_t'(wbReq.stb));
      if (expAccess)
      begin
         checkWord("bus address", expAdr, wbReq.adr);
         checkWord("bus direction", word_t'(expWe), word_t'(wbReq.we));
         checkWord("byte select", 32'h0000_000F, word_t'(wbReq.sel));   // Whole words
         if (expWe)
            checkWord("store data", expDat, wbReq.datOut);
         if (wbAck && expWe)
            dataMem[wbReq.adr[7:2]] = wbReq.datOut;   // Lands at the ack edge
      end
   endtask

   // Slave with 0..3 wait cycles per access
   task automatic driveSlave();
      if (wbAck)
         pending = 1'b0;   // Last access ended at this edge
      if (reset || !wbReq.cyc)
      begin
         pending = 1'b0;
         wbAck   = 1'b0;
      end
      else if (!pending)
      begin
         pending  = 1'b1;
         waitLeft = pickBelow(4);
         wbAck    = (waitLeft == 0);
      end
      else
      begin
         waitLeft = waitLeft - 1;
         wbAck    = (waitLeft == 0);
      end
      wbDatIn = wbAck ? dataMem[wbReq.adr[7:2]] : 32'h0BAD_0BAD;
   endtask

   always @(posedge clk)
   begin
      if (!reset)
      begin
         cycleCount = cycleCount + 1;
         if (cycleCount >= TimeoutCycles)
            stopWithFailure($sformatf("timeout after %0d cycles, pc %h", cycleCount, pc));
      end
   end

   initial
   begin
      int   k;
      logic atSelf;
      seed       = 32'h536b;
      reset      = 1'b1;
      wbAck      = 1'b0;
      wbDatIn    = '0;
      pending    = 1'b0;
      waitLeft   = 0;
      cycleCount = 0;
      atSelf     = 1'b0;
      mPc        = '0;
      mFlags     = '0;
      buildProgram();
      for (k = 0; k < DataWords; k++)
      begin
         dataMem[k] = word_t'(k) * 32'h9E37_79B9 ^ 32'h5A5A_0F0F;   // Scrambled index
         mMem[k]    = dataMem[k];
      end
      for (k = 0; k < 15; k++)
         mRegs[k] = '0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      while (!atSelf)
      begin
         driveSlave();
         @(negedge clk);
         checkCycle();
         atSelf = (pc == word_t'(SelfIdx * 4));
         @(posedge clk);
         #1;
      end
      for (k = 1; k <= 14; k++)
         checkWord($sformatf("stored r%0d", k), mRegs[k], dataMem[k]);
      $display("All checks passed");
      $finish;
   end

endmodule

// ==== armCore.f ====
verilog/armPkg.sv
verilog/armDecoder.sv
verilog/condUnit.sv
verilog/regFile.sv
verilog/armAlu.sv
verilog/armDatapath.sv
verilog/armCore.sv
verification/armBusAssert.sv
verification/armCoreTb.sv

// ==== Makefile ====
TOP := armCoreTb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): armCore.f $(wildcard verilog/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f armCore.f

lint:
	verilator --lint-only -Wall --timing --top-module armCore -f armCore.f

clean:
	rm -rf obj_dir
